// ==== src/la32_pkg.sv ====
package la32_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // bl writes its return address here
    localparam int LINK_REG   = 1;
    localparam int PC_STEP    = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_e;

    // imm is the ALU operand, off is the branch or jump offset
    typedef struct packed {
        alu_op_e   alu_op;
        br_kind_e  br_kind;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_rd;
        logic      uses_src1;
        logic      uses_src2;
        logic      gr_we;
        reg_addr_t dest;
        word_t     imm;
        word_t     off;
    } dec_ctrl_t;

endpackage

// ==== src/la32_if.sv ====
`timescale 1ns/100ps

// decoded packet from decode to execute
interface issue_if import la32_pkg::*; ();
    logic      valid;
    alu_op_e   alu_op;
    word_t     src1;
    word_t     src2;
    logic      gr_we;
    reg_addr_t dest;

    modport source (output valid, alu_op, src1, src2, gr_we, dest);
    modport sink   (input  valid, alu_op, src1, src2, gr_we, dest);
endinterface

// results of execute and writeback, fed back for forwarding
interface bypass_if import la32_pkg::*; ();
    logic      ex_valid;
    reg_addr_t ex_dest;
    word_t     ex_result;
    logic      wb_valid;
    reg_addr_t wb_dest;
    word_t     wb_data;

    modport source (
        output ex_valid, ex_dest, ex_result,
        output wb_valid, wb_dest, wb_data
    );
    modport sink (
        input  ex_valid, ex_dest, ex_result,
        input  wb_valid, wb_dest, wb_data
    );
endinterface

// ==== src/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder import la32_pkg::*; (
    input  word_t     inst,
    output dec_ctrl_t ctrl
);

    // instruction format, picks operands and immediate
    typedef enum logic [3:0] {
        FMT_NONE,
        FMT_RR,
        FMT_RI,
        FMT_RUI,
        FMT_LU12I,
        FMT_PCADDU12I,
        FMT_BCOND,
        FMT_B,
        FMT_BL,
        FMT_JIRL
    } fmt_e;

    typedef struct packed {
        fmt_e     fmt;
        alu_op_e  op;
        br_kind_e kind;
    } sel_t;

    sel_t      sel;
    reg_addr_t rd;
    word_t     imm_si12;
    word_t     imm_ui12;
    word_t     imm_si20;
    word_t     offs16;
    word_t     offs26;

    assign rd       = inst[4:0];
    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui12 = {20'b0, inst[21:10]};
    assign imm_si20 = {inst[24:5], 12'b0};
    assign offs16   = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs26   = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    // opcode fields op[31:26], op[25:22], op[21:20], op[19:15]
    always_comb begin
        casez (inst[31:15])
            17'b000000_0000_01_00000: sel = '{FMT_RR, ALU_ADD, BR_NONE};
            17'b000000_0000_01_00010: sel = '{FMT_RR, ALU_SUB, BR_NONE};
            17'b000000_0000_01_00100: sel = '{FMT_RR, ALU_SLT, BR_NONE};
            17'b000000_0000_01_00101: sel = '{FMT_RR, ALU_SLTU, BR_NONE};
            17'b000000_0000_01_01000: sel = '{FMT_RR, ALU_NOR, BR_NONE};
            17'b000000_0000_01_01001: sel = '{FMT_RR, ALU_AND, BR_NONE};
            17'b000000_0000_01_01010: sel = '{FMT_RR, ALU_OR, BR_NONE};
            17'b000000_0000_01_01011: sel = '{FMT_RR, ALU_XOR, BR_NONE};
            17'b000000_0000_01_01110: sel = '{FMT_RR, ALU_SLL, BR_NONE};
            17'b000000_0000_01_01111: sel = '{FMT_RR, ALU_SRL, BR_NONE};
            17'b000000_0000_01_10000: sel = '{FMT_RR, ALU_SRA, BR_NONE};
            // shift amount is the low five bits of si12
            17'b000000_0001_00_00001: sel = '{FMT_RI, ALU_SLL, BR_NONE};
            17'b000000_0001_00_01001: sel = '{FMT_RI, ALU_SRL, BR_NONE};
            17'b000000_0001_00_10001: sel = '{FMT_RI, ALU_SRA, BR_NONE};
            17'b000000_1000_??_?????: sel = '{FMT_RI, ALU_SLT, BR_NONE};
            17'b000000_1001_??_?????: sel = '{FMT_RI, ALU_SLTU, BR_NONE};
            17'b000000_1010_??_?????: sel = '{FMT_RI, ALU_ADD, BR_NONE};
            17'b000000_1101_??_?????: sel = '{FMT_RUI, ALU_AND, BR_NONE};
            17'b000000_1110_??_?????: sel = '{FMT_RUI, ALU_OR, BR_NONE};
            17'b000000_1111_??_?????: sel = '{FMT_RUI, ALU_XOR, BR_NONE};
            17'b000101_0_??????????:  sel = '{FMT_LU12I, ALU_LUI, BR_NONE};
            17'b000111_0_??????????:  sel = '{FMT_PCADDU12I, ALU_ADD, BR_NONE};
            17'b010011_???????????:   sel = '{FMT_JIRL, ALU_ADD, BR_JIRL};
            17'b010100_???????????:   sel = '{FMT_B, ALU_ADD, BR_B};
            17'b010101_???????????:   sel = '{FMT_BL, ALU_ADD, BR_BL};
            17'b010110_???????????:   sel = '{FMT_BCOND, ALU_ADD, BR_BEQ};
            17'b010111_???????????:   sel = '{FMT_BCOND, ALU_ADD, BR_BNE};
            17'b011000_???????????:   sel = '{FMT_BCOND, ALU_ADD, BR_BLT};
            17'b011001_???????????:   sel = '{FMT_BCOND, ALU_ADD, BR_BGE};
            17'b011010_???????????:   sel = '{FMT_BCOND, ALU_ADD, BR_BLTU};
            17'b011011_???????????:   sel = '{FMT_BCOND, ALU_ADD, BR_BGEU};
            // unknown encodings become a bubble
            default:                  sel = '{FMT_NONE, ALU_ADD, BR_NONE};
        endcase
    end

    always_comb begin
        ctrl.alu_op      = sel.op;
        ctrl.br_kind     = sel.kind;
        ctrl.src1_is_pc  = sel.fmt inside {FMT_PCADDU12I, FMT_BL, FMT_JIRL};
        ctrl.src2_is_imm = sel.fmt inside {FMT_RI, FMT_RUI, FMT_LU12I, FMT_PCADDU12I,
                                           FMT_BL, FMT_JIRL};
        ctrl.src2_is_rd  = (sel.fmt == FMT_BCOND);
        ctrl.uses_src1   = sel.fmt inside {FMT_RR, FMT_RI, FMT_RUI, FMT_BCOND, FMT_JIRL};
        ctrl.uses_src2   = sel.fmt inside {FMT_RR, FMT_BCOND};
        ctrl.gr_we       = !(sel.fmt inside {FMT_NONE, FMT_BCOND, FMT_B});
        ctrl.dest        = (sel.fmt == FMT_BL) ? reg_addr_t'(LINK_REG) : rd;
        case (sel.fmt)
            // link value is pc + 4
            FMT_BL, FMT_JIRL:         ctrl.imm = word_t'(PC_STEP);
            FMT_LU12I, FMT_PCADDU12I: ctrl.imm = imm_si20;
            FMT_RUI:                  ctrl.imm = imm_ui12;
            default:                  ctrl.imm = imm_si12;
        endcase
        ctrl.off = (sel.fmt inside {FMT_B, FMT_BL}) ? offs26 : offs16;
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import la32_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [NUM_REGS];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import la32_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      inst_valid,
    input  word_t     inst,
    input  word_t     pc,
    output logic      br_taken,
    output word_t     br_target,
    issue_if.source   issue,
    bypass_if.sink    bypass,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata
);

    logic              ds_valid;
    logic [INST_W-1:0] ds_inst;
    word_t             ds_pc;
    dec_ctrl_t         ctrl;
    reg_addr_t         raddr1;
    reg_addr_t         raddr2;
    word_t             rdata1;
    word_t             rdata2;
    word_t             rj_value;
    word_t             rkd_value;
    logic              rj_eq_rkd;
    logic              rj_lt_rkd;
    logic              rj_ltu_rkd;
    logic              br_cond;

    // the instruction behind a taken branch is on the wrong path
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else begin
            ds_valid <= inst_valid && !br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            ds_inst <= inst;
            ds_pc   <= pc;
        end
    end

    inst_decoder u_decoder (
        .inst (ds_inst),
        .ctrl (ctrl)
    );

    // branches compare rj with rd, everything else reads rk
    assign raddr1 = ctrl.uses_src1 ? ds_inst[9:5] : '0;
    assign raddr2 = !ctrl.uses_src2 ? '0 :
                    ctrl.src2_is_rd ? ds_inst[4:0] : ds_inst[14:10];

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // r0, then execute, then writeback, then the register file
    function automatic word_t forward(input reg_addr_t addr, input word_t rf_val);
        if (addr == '0) begin
            return '0;
        end else if (bypass.ex_valid && (bypass.ex_dest == addr)) begin
            return bypass.ex_result;
        end else if (bypass.wb_valid && (bypass.wb_dest == addr)) begin
            return bypass.wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        rj_value  = forward(raddr1, rdata1);
        rkd_value = forward(raddr2, rdata2);
    end

    assign rj_eq_rkd  = (rj_value == rkd_value);
    assign rj_lt_rkd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rkd = (rj_value < rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:                 br_cond = rj_eq_rkd;
            BR_BNE:                 br_cond = !rj_eq_rkd;
            BR_BLT:                 br_cond = rj_lt_rkd;
            BR_BGE:                 br_cond = !rj_lt_rkd;
            BR_BLTU:                br_cond = rj_ltu_rkd;
            BR_BGEU:                br_cond = !rj_ltu_rkd;
            BR_B, BR_BL, BR_JIRL:   br_cond = 1'b1;
            default:                br_cond = 1'b0;
        endcase
    end

    assign br_taken  = ds_valid && br_cond;
    assign br_target = (ctrl.br_kind == BR_JIRL) ? rj_value + ctrl.off : ds_pc + ctrl.off;

    assign issue.valid  = ds_valid;
    assign issue.alu_op = ctrl.alu_op;
    assign issue.src1   = ctrl.src1_is_pc ? ds_pc : rj_value;
    assign issue.src2   = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
    assign issue.gr_we  = ctrl.gr_we;
    assign issue.dest   = ctrl.dest;

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import la32_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    issue_if.sink     issue,
    bypass_if.source  bypass,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output logic      wb_valid,
    output reg_addr_t wb_dest,
    output word_t     wb_data
);

    logic      es_wen;
    alu_op_e   es_alu_op;
    word_t     es_src1;
    word_t     es_src2;
    reg_addr_t es_dest;
    logic [4:0] shamt;
    word_t     alu_result;
    logic      wb_valid_r;
    reg_addr_t wb_dest_r;
    word_t     wb_data_r;

    // only register-writing instructions with a nonzero dest count as valid
    always_ff @(posedge clk) begin
        if (reset) begin
            es_wen     <= 1'b0;
            wb_valid_r <= 1'b0;
        end else begin
            es_wen     <= issue.valid && issue.gr_we && (issue.dest != '0);
            wb_valid_r <= es_wen;
        end
    end

    always_ff @(posedge clk) begin
        es_alu_op <= issue.alu_op;
        es_src1   <= issue.src1;
        es_src2   <= issue.src2;
        es_dest   <= issue.dest;
        wb_dest_r <= es_dest;
        wb_data_r <= alu_result;
    end

    assign shamt = es_src2[4:0];

    always_comb begin
        case (es_alu_op)
            ALU_ADD:  alu_result = es_src1 + es_src2;
            ALU_SUB:  alu_result = es_src1 - es_src2;
            ALU_SLT:  alu_result = word_t'($signed(es_src1) < $signed(es_src2));
            ALU_SLTU: alu_result = word_t'(es_src1 < es_src2);
            ALU_AND:  alu_result = es_src1 & es_src2;
            ALU_NOR:  alu_result = ~(es_src1 | es_src2);
            ALU_OR:   alu_result = es_src1 | es_src2;
            ALU_XOR:  alu_result = es_src1 ^ es_src2;
            ALU_SLL:  alu_result = es_src1 << shamt;
            ALU_SRL:  alu_result = es_src1 >> shamt;
            ALU_SRA:  alu_result = $signed(es_src1) >>> shamt;
            default:  alu_result = es_src2;
        endcase
    end

    assign bypass.ex_valid  = es_wen;
    assign bypass.ex_dest   = es_dest;
    assign bypass.ex_result = alu_result;
    assign bypass.wb_valid  = wb_valid_r;
    assign bypass.wb_dest   = wb_dest_r;
    assign bypass.wb_data   = wb_data_r;

    // same register feeds the write port and the outputs
    assign rf_we    = wb_valid_r;
    assign rf_waddr = wb_dest_r;
    assign rf_wdata = wb_data_r;
    assign wb_valid = wb_valid_r;
    assign wb_dest  = wb_dest_r;
    assign wb_data  = wb_data_r;

endmodule

// ==== src/la32_core.sv ====
`timescale 1ns/100ps

module la32_core import la32_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      inst_valid,
    input  word_t     inst,
    input  word_t     pc,
    output logic      br_taken,
    output word_t     br_target,
    output logic      wb_valid,
    output reg_addr_t wb_dest,
    output word_t     wb_data
);

    issue_if  issue_bus ();
    bypass_if bypass_bus ();

    // register file write port
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .issue      (issue_bus.source),
        .bypass     (bypass_bus.sink),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue_bus.sink),
        .bypass   (bypass_bus.source),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data)
    );

endmodule

// ==== tb/la32_core_sva.sv ====
`timescale 1ns/100ps

module la32_core_sva import la32_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      br_taken,
    input word_t     br_target,
    input logic      wb_valid,
    input reg_addr_t wb_dest
);

    int fail_count = 0;

    // outputs settle after the first reset edge
    a_quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!br_taken && !wb_valid))
        else begin
            fail_count++;
            $error("branch or writeback active during reset");
        end

    a_wb_dest_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> (wb_dest != '0))
        else begin
            fail_count++;
            $error("writeback to r0");
        end

    a_target_aligned: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> (br_target[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("branch target not word aligned");
        end

endmodule

// ==== tb/la32_core_tb.sv ====
`timescale 1ns/100ps

module la32_core_tb import la32_pkg::*; ();

    // instructions issued by the register init, reg-reg, immediate, chain, branch and r0 tests
    localparam int NUM_INST = 2 * 31 + 40 + 44 + 24 + 88 + 3;

    logic clk, reset, inst_valid, br_taken, wb_valid;
    word_t inst, pc, br_target, wb_data;
    reg_addr_t wb_dest;
    word_t model [NUM_REGS];
    reg_addr_t exp_dest [$];
    word_t exp_data [$];
    logic exp_taken, cancel;
    word_t exp_target, cur_pc, w;
    int errors, test_start, n_issued;
    logic [16:0] rr_ops [11] = '{17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028,
        17'h00029, 17'h0002a, 17'h0002b, 17'h0002e, 17'h0002f, 17'h00030};

    la32_core la32_core_inst (.*);
    bind la32_core la32_core_sva la32_core_sva_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void exec_inst(input word_t i, input word_t ipc,
            input word_t rf [NUM_REGS], output logic wv, output reg_addr_t wd,
            output word_t wdat, output logic tk, output word_t tg);
        word_t vj, vk, vd, si12, ui12, si20, off16, off26;
        logic we;
        vj = rf[i[9:5]];
        vk = rf[i[14:10]];
        vd = rf[i[4:0]];
        si12 = {{20{i[21]}}, i[21:10]};
        ui12 = {20'b0, i[21:10]};
        si20 = {i[24:5], 12'b0};
        off16 = {{14{i[25]}}, i[25:10], 2'b00};
        off26 = {{4{i[9]}}, i[9:0], i[25:10], 2'b00};
        we = 1'b1;
        wd = i[4:0];
        wdat = '0;
        tk = 1'b0;
        tg = ipc + off16;
        case (i[31:26])
            6'b000000: casez (i[25:15])
                11'b0000_01_00000: wdat = vj + vk;
                11'b0000_01_00010: wdat = vj - vk;
                11'b0000_01_00100: wdat = word_t'($signed(vj) < $signed(vk));
                11'b0000_01_00101: wdat = word_t'(vj < vk);
                11'b0000_01_01000: wdat = ~(vj | vk);
                11'b0000_01_01001: wdat = vj & vk;
                11'b0000_01_01010: wdat = vj | vk;
                11'b0000_01_01011: wdat = vj ^ vk;
                11'b0000_01_01110: wdat = vj << vk[4:0];
                11'b0000_01_01111: wdat = vj >> vk[4:0];
                11'b0000_01_10000: wdat = $signed(vj) >>> vk[4:0];
                11'b0001_00_00001: wdat = vj << i[14:10];
                11'b0001_00_01001: wdat = vj >> i[14:10];
                11'b0001_00_10001: wdat = $signed(vj) >>> i[14:10];
                11'b1000_??_?????: wdat = word_t'($signed(vj) < $signed(si12));
                11'b1001_??_?????: wdat = word_t'(vj < si12);
                11'b1010_??_?????: wdat = vj + si12;
                11'b1101_??_?????: wdat = vj & ui12;
                11'b1110_??_?????: wdat = vj | ui12;
                11'b1111_??_?????: wdat = vj ^ ui12;
                default: we = 1'b0;
            endcase
            6'b000101: begin
                we = !i[25];
                wdat = si20;
            end
            6'b000111: begin
                we = !i[25];
                wdat = ipc + si20;
            end
            6'b010011: begin
                wdat = ipc + 4;
                tk = 1'b1;
                tg = vj + off16;
            end
            6'b010100: begin
                we = 1'b0;
                tk = 1'b1;
                tg = ipc + off26;
            end
            6'b010101: begin
                wd = 5'd1;
                wdat = ipc + 4;
                tk = 1'b1;
                tg = ipc + off26;
            end
            6'b010110: begin
                we = 1'b0;
                tk = (vj == vd);
            end
            6'b010111: begin
                we = 1'b0;
                tk = (vj != vd);
            end
            6'b011000: begin
                we = 1'b0;
                tk = ($signed(vj) < $signed(vd));
            end
            6'b011001: begin
                we = 1'b0;
                tk = ($signed(vj) >= $signed(vd));
            end
            6'b011010: begin
                we = 1'b0;
                tk = (vj < vd);
            end
            6'b011011: begin
                we = 1'b0;
                tk = (vj >= vd);
            end
            default: we = 1'b0;
        endcase
        wv = we && (wd != '0);
    endfunction

    task automatic check_wb(input reg_addr_t d, input word_t v);
        if (wb_dest !== d || wb_data !== v) begin
            errors++;
            $display("Mismatch at %0t: writeback r%0d=%h, expected r%0d=%h",
                     $time, wb_dest, wb_data, d, v);
        end
    endtask

    task automatic check_branch(input logic tk, input word_t tg);
        if (br_taken !== tk || (tk && br_target !== tg)) begin
            errors++;
            $display("Mismatch at %0t: branch %b to %h, expected %b to %h",
                     $time, br_taken, br_target, tk, tg);
        end
    endtask

    // one instruction per falling edge, the branch before it is checked first
    task automatic issue(input word_t i);
        logic wv, tk;
        reg_addr_t wd;
        word_t wdat, tg;
        @(negedge clk);
        check_branch(exp_taken, exp_target);
        exp_taken = 1'b0;
        inst_valid = 1'b1;
        inst = i;
        pc = cur_pc;
        n_issued++;
        if (cancel) begin
            cancel = 1'b0;
        end else begin
            exec_inst(i, cur_pc, model, wv, wd, wdat, tk, tg);
            if (wv) begin
                model[wd] = wdat;
                exp_dest.push_back(wd);
                exp_data.push_back(wdat);
            end
            exp_taken = tk;
            exp_target = tg;
            cancel = tk;
            cur_pc = tk ? tg : cur_pc + 4;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_branch(exp_taken, exp_target);
            exp_taken = 1'b0;
            cancel = 1'b0;
            inst_valid = 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        idle(5);
        $display("test %s done, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    function automatic word_t ri(input logic [9:0] op, input logic [11:0] imm,
                                 input reg_addr_t rj, input reg_addr_t rd);
        return {op, imm, rj, rd};
    endfunction

    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            if (exp_dest.size() == 0) begin
                errors++;
                $display("unexpected writeback to r%0d at %0t", wb_dest, $time);
            end else begin
                check_wb(exp_dest.pop_front(), exp_data.pop_front());
            end
        end
    end

    initial begin
        #((NUM_INST + 100) * 20);
        $display("watchdog timeout, the run did not finish");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reg_addr_t rj, rd;
        void'($urandom(91755));
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        pc = '0;
        cur_pc = 32'h1c00_0000;
        exp_taken = 1'b0;
        exp_target = '0;
        cancel = 1'b0;
        errors = 0;
        test_start = 0;
        n_issued = 0;
        foreach (model[r]) model[r] = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        end_test("reset_idle");
        for (int r = 1; r < NUM_REGS; r++) begin
            issue({7'b0001010, 20'($urandom), 5'(r)});
            issue(ri(10'b0000001110, 12'($urandom), 5'(r), 5'(r)));
        end
        for (int n = 0; n < 40; n++) begin
            w = {rr_ops[$urandom % 11], 5'($urandom % 16), 5'($urandom % 16), 5'd0};
            issue(w | (16 + $urandom % 16));
        end
        end_test("reg_reg_alu");
        for (int n = 0; n < 44; n++) begin
            rj = 5'($urandom);
            rd = 5'(1 + $urandom % 31);
            w = $urandom;
            case (n % 11)
                0: issue(ri(10'b0000001010, w[11:0], rj, rd));
                1: issue(ri(10'b0000001000, w[11:0], rj, rd));
                2: issue(ri(10'b0000001001, w[11:0], rj, rd));
                3: issue(ri(10'b0000001101, w[11:0], rj, rd));
                4: issue(ri(10'b0000001110, w[11:0], rj, rd));
                5: issue(ri(10'b0000001111, w[11:0], rj, rd));
                6: issue(ri(10'b0000000001, {7'b0000001, w[4:0]}, rj, rd));
                7: issue(ri(10'b0000000001, {7'b0001001, w[4:0]}, rj, rd));
                8: issue(ri(10'b0000000001, {7'b0010001, w[4:0]}, rj, rd));
                9: issue({7'b0001010, w[19:0], rd});
                default: issue({7'b0001110, w[19:0], rd});
            endcase
        end
        end_test("immediate_forms");
        for (int gap = 0; gap < 3; gap++) begin
            for (int n = 0; n < 4; n++) begin
                issue({rr_ops[n], 5'($urandom % 8), 5'(20 + n), 5'(21 + n)});
                // andi r0 keeps the slot busy without a writeback
                repeat (gap) issue(ri(10'b0000001101, 12'd0, 5'd0, 5'd0));
            end
        end
        end_test("forward_chains");
        for (int kind = 0; kind < 10; kind++) begin
            for (int n = 0; n < 4; n++) begin
                rj = 5'(1 + $urandom % 15);
                rd = ($urandom % 4 == 0) ? rj : 5'(1 + $urandom % 15);
                w = $urandom;
                if (kind < 6) begin
                    issue({6'(6'b010110 + kind), w[15:0], rj, rd});
                end else if (kind < 8) begin
                    issue({(kind == 6) ? 6'b010100 : 6'b010101, w[15:0], w[25:16]});
                end else begin
                    // lu12i gives an aligned base for jirl
                    issue({7'b0001010, w[19:0], 5'd9});
                    issue({6'b010011, w[31:16], 5'd9, rd});
                end
                issue(ri(10'b0000001010, 12'($urandom), rj, 5'd30));
            end
        end
        end_test("branches");
        issue(ri(10'b0000001010, 12'h123, 5'd3, 5'd0));
        issue({rr_ops[0], 5'd0, 5'd0, 5'd5});
        issue({rr_ops[6], 5'd0, 5'd0, 5'd6});
        end_test("r0_writes");
        errors += la32_core_inst.la32_core_sva_inst.fail_count;
        if (exp_dest.size() != 0) begin
            errors++;
            $display("%0d expected writebacks never appeared", exp_dest.size());
        end
        $display("%0d instructions issued, %0d errors", n_issued, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== la32_core.f ====
src/la32_pkg.sv
src/la32_if.sv
src/inst_decoder.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/la32_core.sv
tb/la32_core_sva.sv
tb/la32_core_tb.sv
